// File: fetch_subsys.f
rtl/fetch_pkg.sv
rtl/imem_if.sv
rtl/fetch_if.sv
rtl/instr_mem.sv
rtl/instr_fetch.sv
rtl/decode_seq.sv
rtl/fetch_subsys.sv
verif/tb_clock_gen.sv
verif/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fetch_tb -f fetch_subsys.f

out=$(./obj_dir/Vfetch_tb)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
else
	exit 1
fi

// File: verif/fetch_tb.sv
// random-program testbench for fetch_subsys that checks every retire against a program-order model
`timescale 1ns/1ps

module fetch_tb
	import fetch_pkg::*;
();

	localparam logic [31:0] LFSR_SEED = 32'h92bb_1a4c;
	// galois taps for x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam int RESET_CYCLES = 16;
	localparam int RETIRE_TIMEOUT = 40;
	localparam int MIN_RETIRE_GAP = 4;

	// program styles
	localparam int MODE_WIDE = 0;
	localparam int MODE_COMP = 1;
	localparam int MODE_MIX = 2;

	logic clock;
	logic reset;
	logic load_en;
	logic [IMEM_AW-1:0] load_addr;
	logic [XLEN-1:0] load_data;
	logic redirect_valid;
	logic [XLEN-1:0] redirect_pc;
	logic retire_valid;
	logic [XLEN-1:0] retire_pc;
	logic [XLEN-1:0] retire_instr;
	logic retire_c;

	logic [31:0] lfsr_state;

	// program as halfwords indexed by address bits 9:1
	logic [15:0] image [2*IMEM_WORDS];

	// reference model state
	logic [XLEN-1:0] model_pc;
	logic [XLEN-1:0] prev_pc;
	logic [XLEN-1:0] jump_target;
	logic jump_pending;

	int cycle;
	int last_retire_cycle;
	int redirects;
	int test_count;
	int test_errors;
	int failed_tests;
	int error_count;

	tb_clock_gen i_clock_gen (
		.clock(clock)
	);

	fetch_subsys i_dut (
		.clock(clock),
		.reset(reset),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_c(retire_c)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic build_image(input int mode);
		logic [31:0] r;
		logic [IMEM_AW:0] h;
		for (int i = 0; i < 2 * IMEM_WORDS; i++) begin
			h = i[IMEM_AW:0];
			r = rand_bits(17);
			if (mode == MODE_WIDE) begin
				// even halves open a 32-bit instr and odd halves hold its upper bits
				image[h] = h[0] ? r[15:0] : {r[15:2], 2'b11};
			end else if (mode == MODE_COMP || !r[16]) begin
				// any low pair but 11 is compressed
				image[h] = {r[15:2], (r[1:0] == 2'b11) ? 2'b01 : r[1:0]};
			end else begin
				image[h] = {r[15:2], 2'b11};
			end
		end
	endtask

	// whole memory written under reset and then the plain reset stretch
	task automatic load_and_reset();
		logic [IMEM_AW-1:0] w;
		reset = 1'b1;
		redirect_valid = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			w = i[IMEM_AW-1:0];
			load_en = 1'b1;
			load_addr = w;
			load_data = {image[{w, 1'b1}], image[{w, 1'b0}]};
			@(negedge clock);
			check_equal("retire_valid", {31'd0, retire_valid}, 32'd0);
		end
		load_en = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clock);
			check_equal("retire_valid", {31'd0, retire_valid}, 32'd0);
		end
		reset = 1'b0;
	endtask

	task automatic check_retire(input int mode, input bit first);
		logic [IMEM_AW:0] h;
		logic [15:0] lo;
		logic [XLEN-1:0] exp_instr;
		logic exp_c;
		h = model_pc[IMEM_AW+1:1];
		lo = image[h];
		// low pair 11 means 32 bits with the upper half from the next halfword
		exp_c = lo[1:0] != 2'b11;
		exp_instr = exp_c ? {16'h0000, lo} : {image[h + 1'b1], lo};
		check_equal("retire_pc", retire_pc, model_pc);
		check_equal("retire_instr", retire_instr, exp_instr);
		check_equal("retire_c", {31'd0, retire_c}, {31'd0, exp_c});
		if (first) begin
			check_equal("retire_pc", retire_pc, RESET_VECTOR);
		end else if (mode == MODE_WIDE) begin
			check_equal("retire_pc", retire_pc, prev_pc + 32'd4);
		end else if (mode == MODE_COMP) begin
			check_equal("retire_pc", retire_pc, prev_pc + 32'd2);
		end
		if (mode == MODE_WIDE) begin
			check_equal("retire_c", {31'd0, retire_c}, 32'd0);
		end else if (mode == MODE_COMP) begin
			check_equal("retire_c", {31'd0, retire_c}, 32'd1);
			check_equal("retire_instr[31:16]", {16'h0000, retire_instr[31:16]}, 32'd0);
		end
		// completion pulses are spaced by the decode latency
		if (!first) begin
			assert (cycle - last_retire_cycle >= MIN_RETIRE_GAP) else begin
				$display("retire pulses only %0d cycles apart, at least %0d expected",
					cycle - last_retire_cycle, MIN_RETIRE_GAP);
				test_errors++;
			end
		end
		last_retire_cycle = cycle;
		prev_pc = model_pc;
		// pending jump takes effect at this completion
		if (jump_pending) begin
			model_pc = jump_target;
			jump_pending = 1'b0;
		end else begin
			model_pc = model_pc + (exp_c ? 32'd2 : 32'd4);
		end
	endtask

	task automatic wait_retire(input int mode, input bit use_redirect, input bit first,
		output bit got);
		logic [31:0] r;
		int waited;
		got = 1'b0;
		waited = 0;
		while (!got && waited < RETIRE_TIMEOUT) begin
			@(negedge clock);
			cycle++;
			waited++;
			if (retire_valid) begin
				check_retire(mode, first);
				got = 1'b1;
			end
			// a pulse driven now lands after any completion sampled above
			redirect_valid = 1'b0;
			if (use_redirect) begin
				r = rand_bits(13);
				if (r[12:9] == 4'h0) begin
					jump_target = RESET_VECTOR + {22'd0, r[8:0], 1'b0};
					jump_pending = 1'b1;
					redirect_valid = 1'b1;
					redirect_pc = jump_target;
					redirects++;
				end
			end
		end
		assert (got) else begin
			$display("no retire within %0d cycles in test %0d", RETIRE_TIMEOUT, test_count);
			test_errors++;
		end
	endtask

	task automatic run_test(input string name, input int mode, input bit use_redirect,
		input int count);
		int retired;
		bit got;
		test_count++;
		test_errors = 0;
		redirects = 0;
		build_image(mode);
		load_and_reset();
		model_pc = RESET_VECTOR;
		prev_pc = RESET_VECTOR;
		jump_pending = 1'b0;
		cycle = 0;
		last_retire_cycle = 0;
		retired = 0;
		got = 1'b1;
		// stop early once a retire goes missing
		while (got && retired < count) begin
			wait_retire(mode, use_redirect, retired == 0, got);
			if (got) begin
				retired++;
			end
		end
		redirect_valid = 1'b0;
		$display("test %0d %s: %0d retires, %0d redirects, %0d errors",
			test_count, name, retired, redirects, test_errors);
		error_count += test_errors;
		if (test_errors != 0) begin
			failed_tests++;
		end
	endtask

	initial begin
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		lfsr_state = LFSR_SEED;
		test_count = 0;
		failed_tests = 0;
		error_count = 0;
		run_test("aligned 32-bit only", MODE_WIDE, 1'b0, 64);
		run_test("compressed only", MODE_COMP, 1'b0, 64);
		run_test("random mix", MODE_MIX, 1'b0, 200);
		run_test("random mix with redirects", MODE_MIX, 1'b1, 200);
		$display("tests run %0d, tests failed %0d, check errors %0d",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verif/tb_clock_gen.sv
// free-running testbench clock for the fetch subsystem, instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock
);

	// 8 ns period
	localparam int HALF_PERIOD_NS = 4;

	// starts low so time-zero drives land before the first rising edge
	initial begin
		clock = 1'b0;
		forever begin
			#HALF_PERIOD_NS clock = ~clock;
		end
	end

endmodule

// File: rtl/fetch_subsys.sv
// top level of the fetch subsystem, memory plus fetch plus decode stand-in behind plain ports
`timescale 1ns/1ps

module fetch_subsys
	import fetch_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic load_en,
	input logic [IMEM_AW-1:0] load_addr,
	input logic [XLEN-1:0] load_data,
	input logic redirect_valid,
	input logic [XLEN-1:0] redirect_pc,
	output logic retire_valid,
	output logic [XLEN-1:0] retire_pc,
	output logic [XLEN-1:0] retire_instr,
	output logic retire_c
);

	// memory read bus
	imem_if i_imem_bus ();

	// fetch to decode link
	fetch_if i_fetch_bus ();

	instr_mem i_mem (
		.clock(clock),
		.reset(reset),
		.bus(i_imem_bus),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

	instr_fetch i_fetch (
		.clock(clock),
		.reset(reset),
		.mem(i_imem_bus),
		.dec(i_fetch_bus)
	);

	// retire stream comes straight from the sequencer
	decode_seq i_decode (
		.clock(clock),
		.reset(reset),
		.fch(i_fetch_bus),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_c(retire_c)
	);

endmodule

// File: rtl/decode_seq.sv
// decode/execute stand-in that holds each instruction a fixed time, retires it and steers fetch
`timescale 1ns/1ps

module decode_seq
	import fetch_pkg::*;
(
	input logic clock,
	input logic reset,
	fetch_if.decode fch,
	input logic redirect_valid,
	input logic [XLEN-1:0] redirect_pc,
	output logic retire_valid,
	output logic [XLEN-1:0] retire_pc,
	output logic [XLEN-1:0] retire_instr,
	output logic retire_c
);

	logic [1:0] state_q;
	logic [DECODE_CNT_W-1:0] exec_cnt_q;

	// pending jump
	logic pend_q;
	logic [XLEN-1:0] target_q;

	// snapshot of the instruction in flight
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] instr_q;
	logic c_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= DEC_WAIT;
			exec_cnt_q <= '0;
		end else begin
			case (state_q)
				DEC_WAIT: begin
					if (fch.fetch_valid) begin
						state_q <= DEC_ACCEPT;
					end
				end
				DEC_ACCEPT: begin
					state_q <= DEC_EXEC;
					exec_cnt_q <= DECODE_CNT_W'(DECODE_CYCLES - 1);
				end
				DEC_EXEC: begin
					// execute stall
					if (exec_cnt_q == '0) begin
						state_q <= DEC_DONE;
					end else begin
						exec_cnt_q <= exec_cnt_q - 1'b1;
					end
				end
				default: begin
					// one cycle of completion then back to waiting
					state_q <= DEC_WAIT;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state_q == DEC_ACCEPT) begin
			pc_q <= fch.pc;
			instr_q <= fch.instr;
			c_q <= fch.instr_c;
		end
	end

	// a new pulse wins over the clear at completion
	always_ff @(posedge clock) begin
		if (reset) begin
			pend_q <= 1'b0;
		end else if (redirect_valid) begin
			pend_q <= 1'b1;
		end else if (fch.decode_complete) begin
			pend_q <= 1'b0;
		end
	end

	// later pulse replaces the target
	always_ff @(posedge clock) begin
		if (redirect_valid) begin
			target_q <= redirect_pc;
		end
	end

	assign fch.decode_complete = state_q == DEC_DONE;
	assign fch.next_pc_seq = !pend_q;
	assign fch.next_pc = target_q;

	assign retire_valid = fch.decode_complete;
	assign retire_pc = pc_q;
	assign retire_instr = instr_q;
	assign retire_c = c_q;

	// single-cycle completion and the completed instr is withdrawn by fetch
	assert property (@(posedge clock) disable iff (reset)
		fch.decode_complete |=> !fch.decode_complete && !fch.fetch_valid)
		else $error("decode_complete held for two cycles or instruction offered again");

endmodule

// File: rtl/instr_fetch.sv
// fetch unit that walks the program counter and assembles 16/32-bit instructions from memory words
`timescale 1ns/1ps

module instr_fetch
	import fetch_pkg::*;
(
	input logic clock,
	input logic reset,
	imem_if.fetch mem,
	fetch_if.fetch dec
);

	logic [1:0] state_q;
	logic [XLEN-1:0] pc_q;

	// buffered upper half of the last word read
	logic [15:0] hbuf_q;
	logic hbuf_valid_q;

	// instruction presented to decode
	logic [XLEN-1:0] instr_q;
	logic instr_c_q;

	fetch_word_u rd_word;
	logic [15:0] low_half;
	logic low_c;
	logic buf_c;
	logic xfer;
	logic hold_en;
	logic buf_load;
	logic [XLEN-1:0] next_instr;
	logic next_c;
	logic [XLEN-1:0] seq_pc;

	assign rd_word = mem.idata;

	// buffered halfword is a whole compressed instruction
	assign buf_c = hbuf_q[1:0] != 2'b11;

	// no memory access when the buffer already holds a compressed instr
	assign mem.ivalid = (state_q == FETCH_REQ) && !(hbuf_valid_q && buf_c);
	// buffer hit with 32-bit instr needs the following word
	assign mem.iaddr = hbuf_valid_q ? {pc_q[XLEN-1:2] + 1'b1, 2'b00} :
		{pc_q[XLEN-1:2], 2'b00};
	assign xfer = mem.ivalid && mem.iready;

	// halfword at pc within the word just read
	assign low_half = pc_q[1] ? rd_word.half[1] : rd_word.half[0];
	assign low_c = low_half[1:0] != 2'b11;

	assign seq_pc = pc_q + (instr_c_q ? XLEN'(2) : XLEN'(4));

	// what to capture this cycle
	always_comb begin
		hold_en = 1'b0;
		buf_load = 1'b0;
		next_instr = {16'h0000, hbuf_q};
		next_c = 1'b1;
		if (state_q == FETCH_REQ) begin
			if (hbuf_valid_q) begin
				if (buf_c) begin
					// compressed straight from the buffer
					hold_en = 1'b1;
				end else if (xfer) begin
					// straddle completes and the new word's upper half comes next
					hold_en = 1'b1;
					buf_load = 1'b1;
					next_instr = {rd_word.half[0], hbuf_q};
					next_c = 1'b0;
				end
			end else if (xfer) begin
				if (low_c) begin
					// keep the upper half when it follows this one
					hold_en = 1'b1;
					buf_load = !pc_q[1];
					next_instr = {16'h0000, low_half};
					next_c = 1'b1;
				end else if (!pc_q[1]) begin
					hold_en = 1'b1;
					next_instr = rd_word.word;
					next_c = 1'b0;
				end else begin
					// first half of a straddling instr so fetch the rest
					buf_load = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= FETCH_START;
			pc_q <= RESET_VECTOR;
			hbuf_valid_q <= 1'b0;
		end else begin
			case (state_q)
				FETCH_START: begin
					state_q <= FETCH_REQ;
				end
				FETCH_REQ: begin
					if (hold_en || buf_load) begin
						hbuf_valid_q <= buf_load;
					end
					if (hold_en) begin
						state_q <= FETCH_HOLD;
					end
				end
				FETCH_HOLD: begin
					if (dec.decode_complete) begin
						state_q <= FETCH_REQ;
						if (dec.next_pc_seq) begin
							pc_q <= seq_pc;
						end else begin
							// buffered half belongs to the old stream on a jump
							pc_q <= {dec.next_pc[XLEN-1:1], 1'b0};
							hbuf_valid_q <= 1'b0;
						end
					end
				end
				default: begin
					state_q <= FETCH_START;
				end
			endcase
		end
	end

	// payload regs
	always_ff @(posedge clock) begin
		if (hold_en) begin
			instr_q <= next_instr;
			instr_c_q <= next_c;
		end
		if (buf_load) begin
			hbuf_q <= rd_word.half[1];
		end
	end

	assign dec.fetch_valid = state_q == FETCH_HOLD;
	assign dec.instr = instr_q;
	assign dec.instr_c = instr_c_q;
	assign dec.pc = pc_q;

	// offered instruction stays put until decode takes it
	assert property (@(posedge clock) disable iff (reset)
		dec.fetch_valid && !dec.decode_complete |=>
		dec.fetch_valid && $stable(dec.instr) && $stable(dec.pc))
		else $error("fetch_valid dropped or payload changed before decode_complete");

	// path's compressed flag matches the opcode bits and the upper half is zero when compressed
	assert property (@(posedge clock) disable iff (reset)
		dec.fetch_valid |->
		(dec.instr_c == (dec.instr[1:0] != 2'b11)) &&
		(!dec.instr_c || dec.instr[31:16] == 16'h0000))
		else $error("instr_c disagrees with instruction bits");

endmodule

// File: rtl/instr_mem.sv
// instruction word memory, loaded through a write port and read by fetch with alternating grants
`timescale 1ns/1ps

module instr_mem
	import fetch_pkg::*;
(
	input logic clock,
	input logic reset,
	imem_if.mem bus,
	input logic load_en,
	input logic [IMEM_AW-1:0] load_addr,
	input logic [XLEN-1:0] load_data
);

	// word storage, contents only come from the load port
	logic [XLEN-1:0] mem_q [IMEM_WORDS];

	// grant toggle
	logic ready_q;

	// word index from the byte address
	logic [IMEM_AW-1:0] rd_idx;

	// load port, written only while the core sits in reset
	always_ff @(posedge clock) begin
		if (load_en) begin
			mem_q[load_addr] <= load_data;
		end
	end

	// upper address bits ignored, memory aliases across the space
	assign rd_idx = bus.iaddr[IMEM_AW+1:2];

	// async read, fetch samples it in the grant cycle
	assign bus.idata = mem_q[rd_idx];

	// flips on every edge with a request pending
	// so a request waits zero or one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			ready_q <= 1'b0;
		end else if (bus.ivalid) begin
			ready_q <= ~ready_q;
		end
	end

	assign bus.iready = ready_q;

	// requester must hold address and request across an ungranted cycle
	assert property (@(posedge clock) disable iff (reset)
		bus.ivalid && !bus.iready |=> bus.ivalid && $stable(bus.iaddr))
		else $error("iaddr changed or ivalid dropped before grant");

endmodule

// File: rtl/fetch_if.sv
// link between fetch unit and decode sequencer, carries instructions one way and next pc the other
`timescale 1ns/1ps

interface fetch_if
	import fetch_pkg::*;
();

	// fetch side, held stable until decode_complete
	logic fetch_valid;
	logic [XLEN-1:0] instr;
	logic instr_c;
	logic [XLEN-1:0] pc;

	// decode side, next_pc fields only meaningful with decode_complete
	logic decode_complete;
	logic [XLEN-1:0] next_pc;
	logic next_pc_seq;

	modport fetch (
		output fetch_valid,
		output instr,
		output instr_c,
		output pc,
		input decode_complete,
		input next_pc,
		input next_pc_seq
	);

	modport decode (
		input fetch_valid,
		input instr,
		input instr_c,
		input pc,
		output decode_complete,
		output next_pc,
		output next_pc_seq
	);

endinterface

// File: rtl/imem_if.sv
// instruction-memory read bus, fetch unit drives requests and the memory grants them
`timescale 1ns/1ps

interface imem_if
	import fetch_pkg::*;
();

	// word-aligned read address, held while ivalid waits for a grant
	logic [XLEN-1:0] iaddr;
	logic ivalid;
	// combinational read data, valid in the transfer cycle
	logic [XLEN-1:0] idata;
	// alternating grant from the memory
	logic iready;

	modport fetch (
		output iaddr,
		output ivalid,
		input idata,
		input iready
	);

	modport mem (
		input iaddr,
		input ivalid,
		output idata,
		output iready
	);

endinterface

// File: rtl/fetch_pkg.sv
// shared widths, reset vector, memory depth, FSM encodings and fetched-word view; import with fetch_pkg::*
package fetch_pkg;

	// address and data width
	localparam int XLEN = 32;

	// first fetch address out of reset
	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;

	// instruction memory depth in 32-bit words
	localparam int IMEM_WORDS = 256;
	// word index taken from address bits 9:2
	localparam int IMEM_AW = 8;

	// execute stall between accept and retire
	localparam int DECODE_CYCLES = 2;
	localparam int DECODE_CNT_W = $clog2(DECODE_CYCLES + 1);

	// fetch FSM encodings
	localparam logic [1:0] FETCH_START = 2'd0;
	localparam logic [1:0] FETCH_REQ = 2'd1;
	localparam logic [1:0] FETCH_HOLD = 2'd2;

	// decode sequencer encodings
	localparam logic [1:0] DEC_WAIT = 2'd0;
	localparam logic [1:0] DEC_ACCEPT = 2'd1;
	localparam logic [1:0] DEC_EXEC = 2'd2;
	localparam logic [1:0] DEC_DONE = 2'd3;

	// one memory word, either whole or as two halfwords
	// half[0] is the lower address, half[1] the upper one
	typedef union packed {
		logic [XLEN-1:0] word;
		logic [1:0][15:0] half;
	} fetch_word_u;

endpackage
